/* lc4ss.f */
+incdir+include
verilog/lc4ss_pkg.sv
verilog/lc4ss_decoder.sv
verilog/lc4ss_regfile.sv
verilog/lc4ss_alu.sv
verilog/lc4ss_bypass.sv
verilog/lc4ss_hazard_ctrl.sv
verilog/lc4ss_core.sv
tests/lc4ss_sva.sv
tests/lc4ss_checker.sv
tests/lc4ss_tb.sv

/* Makefile */
# Verilator build and run for the lc4ss dual-issue core

VERILATOR ?= verilator
TOP       ?= lc4ss_tb
FILELIST  ?= lc4ss.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Test FAILED
PASS_MSG  ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/lc4ss_stim.txt */
# tag address data, all hex
# I = program word, D = initial data word, E = expected store in program order
I 8200 9E40
I 8201 9205
I 8202 95FD
I 8203 1627
I 8204 1842
I 8205 5A43
I 8206 79C0
I 8207 7BC1
I 8208 1261
I 8209 1441
I 820A 75C2
I 820B 1C3F
I 820C 67D0
I 820D 18C6
I 820E 79C3
I 820F 7DC4
I 8210 9A00
I 8211 63D1
I 8212 1441
I 8213 75C5
I 8214 97FF
I 8215 0802
I 8216 77C6
I 8217 77C7
I 8218 0401
I 8219 7BC8
I 821A 0FFF
D 0050 0123
D 0051 00FF
E 0040 0002
E 0041 0005
E 0042 000C
E 0043 0122
E 0044 FFFF
E 0045 01FE
E 0048 0000

/* tests/lc4ss_tb.sv */
`timescale 1ns/1ps
`include "lc4ss_macros.svh"

module lc4ss_tb;

    logic              gwe;
    logic              i_rst;
    logic [`LC4_W-1:0] o_cur_pc;
    logic [`LC4_W-1:0] i_insn_a;
    logic [`LC4_W-1:0] i_insn_b;
    logic [`LC4_W-1:0] o_dmem_addr;
    logic [`LC4_W-1:0] i_dmem_rdata;
    logic              o_dmem_we;
    logic [`LC4_W-1:0] o_dmem_wdata;

    logic              chk_done;
    int                chk_errors;
    int                chk_seen;
    int                chk_expected;
    int                tb_errors;

    logic [`LC4_W-1:0] imem [0:65535];
    logic [`LC4_W-1:0] dmem [0:65535];

    lc4ss_core lc4ss_core_inst (
        .gwe          (gwe),
        .i_rst        (i_rst),
        .o_cur_pc     (o_cur_pc),
        .i_insn_a     (i_insn_a),
        .i_insn_b     (i_insn_b),
        .o_dmem_addr  (o_dmem_addr),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_wdata (o_dmem_wdata)
    );

    lc4ss_checker u_checker (
        .gwe          (gwe),
        .i_rst        (i_rst),
        .i_dmem_addr  (o_dmem_addr),
        .i_dmem_we    (o_dmem_we),
        .i_dmem_wdata (o_dmem_wdata),
        .o_done       (chk_done),
        .o_errors     (chk_errors),
        .o_seen       (chk_seen),
        .o_expected   (chk_expected)
    );

    bind lc4ss_core lc4ss_sva u_sva (
        .gwe       (gwe),
        .i_rst     (i_rst),
        .o_cur_pc  (o_cur_pc),
        .o_dmem_we (o_dmem_we)
    );

    // combinational instruction and data reads
    assign i_insn_a     = imem[o_cur_pc];
    assign i_insn_b     = imem[o_cur_pc + 16'd1];
    assign i_dmem_rdata = dmem[o_dmem_addr];

    always @(posedge gwe) begin
        if (o_dmem_we === 1'b1) begin
            dmem[o_dmem_addr] <= o_dmem_wdata;
        end
    end

    initial begin
        gwe = 1'b0;
        forever begin
            #10 gwe = ~gwe;
        end
    end

    // fill first and then overlay I and D records from the stimulus file
    task automatic load_memories();
        int                fd;
        int                code;
        logic              eof;
        string             tag;
        logic [8*128-1:0]  line;
        logic [`LC4_W-1:0] a;
        logic [`LC4_W-1:0] d;
        // opcode 1111 decodes to nop and the low bits follow the address
        for (int i = 0; i < 65536; i++) begin
            imem[i] = {4'hf, i[11:0] ^ i[15:4]};
            dmem[i] = {i[7:0] ^ i[15:8], i[15:8] ^ 8'ha5};
        end
        eof = 1'b0;
        fd = $fopen("tests/lc4ss_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            tb_errors = tb_errors + 1;
            eof = 1'b1;
        end
        while (!eof) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                eof = 1'b1;
            end else if (tag == "#") begin
                code = $fgets(line, fd);
            end else begin
                code = $fscanf(fd, "%h %h", a, d);
                if (tag == "I") begin
                    imem[a] = d;
                end else if (tag == "D") begin
                    dmem[a] = d;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    initial begin
        int cycles;
        tb_errors = 0;
        i_rst     = 1'b1;
        load_memories();
        repeat (5) @(posedge gwe);
        @(negedge gwe);
        i_rst = 1'b0;
        if (o_cur_pc !== `LC4_RESET_PC) begin
            $display("Mismatch at %0t: o_cur_pc got %h expected %h",
                     $time, o_cur_pc, `LC4_RESET_PC);
            tb_errors = tb_errors + 1;
        end
        // wait for every expected store
        cycles = 0;
        while (!chk_done && cycles < 500) begin
            @(negedge gwe);
            cycles = cycles + 1;
        end
        if (!chk_done) begin
            $display("program did not finish: %0d of %0d stores seen",
                     chk_seen, chk_expected);
            tb_errors = tb_errors + 1;
        end else begin
            // the self loop must stay quiet
            cycles = 0;
            while (cycles < 50) begin
                @(negedge gwe);
                cycles = cycles + 1;
            end
        end
        $display("errors: %0d checker, %0d testbench, %0d assertion",
                 chk_errors, tb_errors, lc4ss_core_inst.u_sva.fail_count);
        if (chk_errors == 0 && tb_errors == 0 &&
            lc4ss_core_inst.u_sva.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* tests/lc4ss_checker.sv */
`timescale 1ns/1ps
`include "lc4ss_macros.svh"

module lc4ss_checker (
    input  logic              gwe,
    input  logic              i_rst,
    input  logic [`LC4_W-1:0] i_dmem_addr,
    input  logic              i_dmem_we,
    input  logic [`LC4_W-1:0] i_dmem_wdata,
    output logic              o_done,
    output int                o_errors,
    output int                o_seen,
    output int                o_expected
);

    logic [`LC4_W-1:0] exp_addr [$];
    logic [`LC4_W-1:0] exp_data [$];

    // only the E records matter here
    initial begin
        int                fd;
        int                code;
        logic              eof;
        string             tag;
        logic [8*128-1:0]  line;
        logic [`LC4_W-1:0] a;
        logic [`LC4_W-1:0] d;
        o_errors = 0;
        o_seen   = 0;
        eof      = 1'b0;
        fd = $fopen("tests/lc4ss_stim.txt", "r");
        if (fd == 0) begin
            $display("checker cannot open the stimulus file");
            o_errors = o_errors + 1;
            eof = 1'b1;
        end
        while (!eof) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                eof = 1'b1;
            end else if (tag == "#") begin
                code = $fgets(line, fd);
            end else begin
                code = $fscanf(fd, "%h %h", a, d);
                if (tag == "E") begin
                    exp_addr.push_back(a);
                    exp_data.push_back(d);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        o_expected = exp_addr.size();
    end

    assign o_done = (o_seen == o_expected);

    // sampled at the rising edge, the same edge that commits the write
    always @(posedge gwe) begin
        if (!i_rst && i_dmem_we === 1'b1) begin
            if (o_seen >= o_expected) begin
                $display("unexpected store at %0t: addr %h data %h",
                         $time, i_dmem_addr, i_dmem_wdata);
                o_errors = o_errors + 1;
            end else begin
                if (i_dmem_addr !== exp_addr[o_seen]) begin
                    $display("Mismatch at %0t: o_dmem_addr got %h expected %h",
                             $time, i_dmem_addr, exp_addr[o_seen]);
                    o_errors = o_errors + 1;
                end
                if (i_dmem_wdata !== exp_data[o_seen]) begin
                    $display("Mismatch at %0t: o_dmem_wdata got %h expected %h",
                             $time, i_dmem_wdata, exp_data[o_seen]);
                    o_errors = o_errors + 1;
                end
            end
            o_seen = o_seen + 1;
        end
    end

endmodule

/* tests/lc4ss_sva.sv */
`timescale 1ns/1ps
`include "lc4ss_macros.svh"

module lc4ss_sva (
    input logic              gwe,
    input logic              i_rst,
    input logic [`LC4_W-1:0] o_cur_pc,
    input logic              o_dmem_we
);

    // running count of failed checks
    int fail_count = 0;

    // write strobe must always resolve once out of reset
    a_we_known: assert property (@(posedge gwe) disable iff (i_rst) !$isunknown(o_dmem_we))
        else begin
            $error("data write strobe is unknown");
            fail_count = fail_count + 1;
        end

    // first cycle after reset fetches from the reset vector
    a_reset_pc: assert property (@(posedge gwe) $fell(i_rst) |-> o_cur_pc == `LC4_RESET_PC)
        else begin
            $error("fetch pc is not the reset vector after reset");
            fail_count = fail_count + 1;
        end

    // no store while reset holds after the valid bits have cleared
    a_no_store_in_reset: assert property (@(posedge gwe) i_rst && $past(i_rst) |-> !o_dmem_we)
        else begin
            $error("store issued during reset");
            fail_count = fail_count + 1;
        end

endmodule

/* verilog/lc4ss_core.sv */
`timescale 1ns/1ps
`include "lc4ss_macros.svh"

module lc4ss_core import lc4ss_pkg::*; (
    input  logic              gwe,
    input  logic              i_rst,
    output logic [`LC4_W-1:0] o_cur_pc,
    input  logic [`LC4_W-1:0] i_insn_a,
    input  logic [`LC4_W-1:0] i_insn_b,
    output logic [`LC4_W-1:0] o_dmem_addr,
    input  logic [`LC4_W-1:0] i_dmem_rdata,
    output logic              o_dmem_we,
    output logic [`LC4_W-1:0] o_dmem_wdata
);

    // lane a always holds the older slot of each stage pair
    slot_t d_a;
    slot_t d_b;
    slot_t x_a;
    slot_t x_b;
    slot_t m_a;
    slot_t m_b;
    slot_t w_a;
    slot_t w_b;

    decoded_t dec_raw_a;
    decoded_t dec_raw_b;
    decoded_t dec_a;
    decoded_t dec_b;
    slot_t    iss_a;
    slot_t    iss_b;
    slot_t    x_fwd_a;
    slot_t    x_fwd_b;
    slot_t    x_res_a;
    slot_t    x_res_b;

    logic [`LC4_W-1:0]     rf_rs_a;
    logic [`LC4_W-1:0]     rf_rt_a;
    logic [`LC4_W-1:0]     rf_rs_b;
    logic [`LC4_W-1:0]     rf_rt_b;
    logic [`LC4_W-1:0]     fw_rs_a;
    logic [`LC4_W-1:0]     fw_rt_a;
    logic [`LC4_W-1:0]     fw_rs_b;
    logic [`LC4_W-1:0]     fw_rt_b;
    logic [`LC4_W-1:0]     store_data;
    logic [`LC4_W-1:0]     alu_a;
    logic [`LC4_W-1:0]     alu_b;
    logic [`LC4_NZP_W-1:0] alu_nzp_a;
    logic [`LC4_NZP_W-1:0] alu_nzp_b;
    logic [`LC4_NZP_W-1:0] m_nzp_a;
    logic [`LC4_NZP_W-1:0] m_nzp_b;
    logic [`LC4_NZP_W-1:0] nzp_reg;
    logic [`LC4_NZP_W-1:0] nzp_cur;

    issue_e            issue;
    logic              kill_x_b;
    logic [`LC4_W-1:0] target;
    logic              m_mem_a;
    logic              m_mem_b;

    // fresh decode entry straight from imem
    function automatic slot_t fetch_slot(input logic [`LC4_W-1:0] pc,
                                         input logic [`LC4_W-1:0] insn);
        slot_t s;
        s       = '0;
        s.valid = 1'b1;
        s.pc    = pc;
        s.insn  = insn;
        return s;
    endfunction

    lc4ss_decoder u_dec_a (.i_insn(d_a.insn), .o_dec(dec_raw_a));
    lc4ss_decoder u_dec_b (.i_insn(d_b.insn), .o_dec(dec_raw_b));

    // empty decode slots look like nops to the control
    assign dec_a = d_a.valid ? dec_raw_a : '0;
    assign dec_b = d_b.valid ? dec_raw_b : '0;

    lc4ss_regfile u_regfile (
        .gwe    (gwe),
        .i_rst  (i_rst),
        .i_rs_a (dec_a.rs),
        .i_rt_a (dec_a.rt),
        .i_rs_b (dec_b.rs),
        .i_rt_b (dec_b.rt),
        .o_rs_a (rf_rs_a),
        .o_rt_a (rf_rt_a),
        .o_rs_b (rf_rs_b),
        .o_rt_b (rf_rt_b),
        .i_wr_a (w_a),
        .i_wr_b (w_b)
    );

    // decode slots as they would enter x
    always_comb begin
        iss_a        = d_a;
        iss_a.dec    = dec_a;
        iss_a.rs_val = rf_rs_a;
        iss_a.rt_val = rf_rt_a;
        iss_a.result = '0;
        iss_b        = d_b;
        iss_b.dec    = dec_b;
        iss_b.rs_val = rf_rs_b;
        iss_b.rt_val = rf_rt_b;
        iss_b.result = '0;
    end

    lc4ss_bypass u_bypass (
        .i_x_a        (x_a),
        .i_x_b        (x_b),
        .i_m_a        (m_a),
        .i_m_b        (m_b),
        .i_w_a        (w_a),
        .i_w_b        (w_b),
        .o_rs_a       (fw_rs_a),
        .o_rt_a       (fw_rt_a),
        .o_rs_b       (fw_rs_b),
        .o_rt_b       (fw_rt_b),
        .o_store_data (store_data)
    );

    // x slots with forwarded operands and then the alu result
    always_comb begin
        x_fwd_a        = x_a;
        x_fwd_a.rs_val = fw_rs_a;
        x_fwd_a.rt_val = fw_rt_a;
        x_fwd_b        = x_b;
        x_fwd_b.rs_val = fw_rs_b;
        x_fwd_b.rt_val = fw_rt_b;
        x_res_a        = x_fwd_a;
        x_res_a.result = alu_a;
        x_res_b        = x_fwd_b;
        x_res_b.result = alu_b;
    end

    lc4ss_alu u_alu_a (.i_slot(x_fwd_a), .o_result(alu_a), .o_nzp(alu_nzp_a));
    lc4ss_alu u_alu_b (.i_slot(x_fwd_b), .o_result(alu_b), .o_nzp(alu_nzp_b));

    lc4ss_hazard_ctrl u_hazard_ctrl (
        .i_dec_a    (dec_a),
        .i_dec_b    (dec_b),
        .i_x_a      (x_res_a),
        .i_x_b      (x_res_b),
        .i_nzp      (nzp_cur),
        .o_issue    (issue),
        .o_redirect (),
        .o_target   (target),
        .o_kill_x_b (kill_x_b)
    );

    // nzp after the m pair retires
    // younger lane b wins
    always_comb begin
        nzp_cur = nzp_reg;
        if (m_a.valid && m_a.dec.nzp_we) begin
            nzp_cur = m_a.dec.is_load ? nzp_of(i_dmem_rdata) : m_nzp_a;
        end
        if (m_b.valid && m_b.dec.nzp_we) begin
            nzp_cur = m_b.dec.is_load ? nzp_of(i_dmem_rdata) : m_nzp_b;
        end
    end

    // the switch rule keeps at most one memory op in m
    // so both lanes share one data port
    assign m_mem_a      = m_a.valid && (m_a.dec.is_load || m_a.dec.is_store);
    assign m_mem_b      = m_b.valid && (m_b.dec.is_load || m_b.dec.is_store);
    assign o_dmem_addr  = m_mem_a ? m_a.result : (m_mem_b ? m_b.result : '0);
    assign o_dmem_we    = (m_a.valid && m_a.dec.is_store) || (m_b.valid && m_b.dec.is_store);
    assign o_dmem_wdata = store_data;

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            o_cur_pc <= `LC4_RESET_PC;
            d_a.valid <= 1'b0;
            d_b.valid <= 1'b0;
            x_a.valid <= 1'b0;
            x_b.valid <= 1'b0;
            m_a.valid <= 1'b0;
            m_b.valid <= 1'b0;
            w_a.valid <= 1'b0;
            w_b.valid <= 1'b0;
            nzp_reg   <= 3'b010;
        end else begin
            // m and w never stall
            m_a       <= x_res_a;
            m_b       <= x_res_b;
            m_b.valid <= x_res_b.valid && !kill_x_b;
            m_nzp_a   <= alu_nzp_a;
            m_nzp_b   <= alu_nzp_b;
            w_a        <= m_a;
            w_a.result <= m_a.dec.is_load ? i_dmem_rdata : m_a.result;
            w_b        <= m_b;
            w_b.result <= m_b.dec.is_load ? i_dmem_rdata : m_b.result;
            nzp_reg   <= nzp_cur;
            case (issue)
                ISSUE_FLUSH: begin
                    o_cur_pc  <= target;
                    d_a.valid <= 1'b0;
                    d_b.valid <= 1'b0;
                    x_a.valid <= 1'b0;
                    x_b.valid <= 1'b0;
                end
                ISSUE_STALL: begin
                    // pc and decode hold while bubbles enter x
                    x_a.valid <= 1'b0;
                    x_b.valid <= 1'b0;
                end
                ISSUE_SWITCH: begin
                    // older goes alone and younger moves up to lane a
                    o_cur_pc  <= o_cur_pc + 16'd1;
                    x_a       <= iss_a;
                    x_b.valid <= 1'b0;
                    d_a       <= d_b;
                    d_b       <= fetch_slot(o_cur_pc, i_insn_a);
                end
                default: begin
                    o_cur_pc <= o_cur_pc + 16'd2;
                    x_a      <= iss_a;
                    x_b      <= iss_b;
                    d_a      <= fetch_slot(o_cur_pc, i_insn_a);
                    d_b      <= fetch_slot(o_cur_pc + 16'd1, i_insn_b);
                end
            endcase
        end
    end

endmodule

/* verilog/lc4ss_hazard_ctrl.sv */
`timescale 1ns/1ps
`include "lc4ss_macros.svh"

module lc4ss_hazard_ctrl import lc4ss_pkg::*; (
    input  decoded_t              i_dec_a,
    input  decoded_t              i_dec_b,
    input  slot_t                 i_x_a,
    input  slot_t                 i_x_b,
    input  logic [`LC4_NZP_W-1:0] i_nzp,
    output issue_e                o_issue,
    output logic                  o_redirect,
    output logic [`LC4_W-1:0]     o_target,
    output logic                  o_kill_x_b
);

    logic [`LC4_NZP_W-1:0] nzp_b;
    logic                  taken_a;
    logic                  taken_b;
    logic                  b_needs_a;
    logic                  mem_pair;
    logic                  switch_b;
    logic                  stall;

    // operand needed in execute
    // store data is only needed in m and is covered by wm/mm forwarding
    function automatic logic reads_x(input decoded_t d, input logic [`LC4_RSEL_W-1:0] r);
        return (d.rs_re && d.rs == r) || (d.rt_re && !d.is_store && d.rt == r);
    endfunction

    // load in x blocks a consumer in d, a br too since the load sets nzp
    function automatic logic load_use(input slot_t x, input decoded_t d);
        return x.valid && x.dec.is_load && (reads_x(d, x.dec.rd) || d.is_branch);
    endfunction

    // lane b branch sees lane a's nzp update first
    assign nzp_b = (i_x_a.valid && i_x_a.dec.nzp_we && !i_x_a.dec.is_load) ?
                   nzp_of(i_x_a.result) : i_nzp;

    assign taken_a = i_x_a.valid && i_x_a.dec.is_branch && |(i_x_a.dec.br_cond & i_nzp);
    assign taken_b = i_x_b.valid && i_x_b.dec.is_branch && |(i_x_b.dec.br_cond & nzp_b);

    assign o_redirect = taken_a || taken_b;
    // alu already holds pc+1+imm9 as the result
    assign o_target   = taken_a ? i_x_a.result : i_x_b.result;
    // younger x slot is wrong-path only when lane a branches
    assign o_kill_x_b = taken_a;

    // decode pair dependences
    assign b_needs_a = (i_dec_a.reg_we && reads_x(i_dec_b, i_dec_a.rd)) ||
                       (i_dec_b.is_branch && i_dec_a.nzp_we);
    // one data memory port
    assign mem_pair  = (i_dec_a.is_load || i_dec_a.is_store) &&
                       (i_dec_b.is_load || i_dec_b.is_store);
    assign switch_b  = b_needs_a || mem_pair;

    // lane b only counts when it would issue with lane a
    assign stall = load_use(i_x_a, i_dec_a) || load_use(i_x_b, i_dec_a) ||
                   (!switch_b && (load_use(i_x_a, i_dec_b) || load_use(i_x_b, i_dec_b)));

    always_comb begin
        if (o_redirect) begin
            o_issue = ISSUE_FLUSH;
        end else if (stall) begin
            o_issue = ISSUE_STALL;
        end else if (switch_b) begin
            o_issue = ISSUE_SWITCH;
        end else begin
            o_issue = ISSUE_PAIR;
        end
    end

endmodule

/* verilog/lc4ss_bypass.sv */
`timescale 1ns/1ps
`include "lc4ss_macros.svh"

module lc4ss_bypass import lc4ss_pkg::*; (
    input  slot_t             i_x_a,
    input  slot_t             i_x_b,
    input  slot_t             i_m_a,
    input  slot_t             i_m_b,
    input  slot_t             i_w_a,
    input  slot_t             i_w_b,
    output logic [`LC4_W-1:0] o_rs_a,
    output logic [`LC4_W-1:0] o_rt_a,
    output logic [`LC4_W-1:0] o_rs_b,
    output logic [`LC4_W-1:0] o_rt_b,
    output logic [`LC4_W-1:0] o_store_data
);

    // producer slot writes the selected register
    function automatic logic hit(input slot_t s, input logic [`LC4_RSEL_W-1:0] sel);
        return s.valid && s.dec.reg_we && (s.dec.rd == sel);
    endfunction

    // later checks override earlier ones
    // priority is m lane b, m lane a, w lane b, w lane a, register value
    function automatic logic [`LC4_W-1:0] fwd_x(
        input logic [`LC4_RSEL_W-1:0] sel,
        input logic [`LC4_W-1:0]      reg_val
    );
        logic [`LC4_W-1:0] value;
        value = reg_val;
        if (hit(i_w_a, sel)) begin
            value = i_w_a.result;
        end
        if (hit(i_w_b, sel)) begin
            value = i_w_b.result;
        end
        if (hit(i_m_a, sel)) begin
            value = i_m_a.result;
        end
        if (hit(i_m_b, sel)) begin
            value = i_m_b.result;
        end
        return value;
    endfunction

    // mx and wx into both execute lanes
    always_comb begin
        o_rs_a = fwd_x(i_x_a.dec.rs, i_x_a.rs_val);
        o_rt_a = fwd_x(i_x_a.dec.rt, i_x_a.rt_val);
        o_rs_b = fwd_x(i_x_b.dec.rs, i_x_b.rs_val);
        o_rt_b = fwd_x(i_x_b.dec.rt, i_x_b.rt_val);
    end

    // store data in m, at most one memory op sits there
    always_comb begin
        if (i_m_b.valid && i_m_b.dec.is_store) begin
            o_store_data = i_m_b.rt_val;
            if (hit(i_w_a, i_m_b.dec.rt)) begin
                o_store_data = i_w_a.result;
            end
            if (hit(i_w_b, i_m_b.dec.rt)) begin
                o_store_data = i_w_b.result;
            end
            // older lane a in the same m pair is the newest producer
            if (hit(i_m_a, i_m_b.dec.rt)) begin
                o_store_data = i_m_a.result;
            end
        end else begin
            o_store_data = i_m_a.rt_val;
            if (hit(i_w_a, i_m_a.dec.rt)) begin
                o_store_data = i_w_a.result;
            end
            if (hit(i_w_b, i_m_a.dec.rt)) begin
                o_store_data = i_w_b.result;
            end
        end
    end

endmodule

/* verilog/lc4ss_alu.sv */
`timescale 1ns/1ps
`include "lc4ss_macros.svh"

module lc4ss_alu import lc4ss_pkg::*; (
    input  slot_t                 i_slot,
    output logic [`LC4_W-1:0]     o_result,
    output logic [`LC4_NZP_W-1:0] o_nzp
);

    always_comb begin
        case (i_slot.dec.opcode)
            OP_ADD: begin
                o_result = i_slot.rs_val + i_slot.rt_val;
            end
            // ldr and str share the rs + imm6 address path
            OP_ADDI, OP_LDR, OP_STR: begin
                o_result = i_slot.rs_val + i_slot.dec.imm;
            end
            OP_AND: begin
                o_result = i_slot.rs_val & i_slot.rt_val;
            end
            OP_CONST: begin
                o_result = i_slot.dec.imm;
            end
            // branch target pc+1+imm9
            OP_BR: begin
                o_result = i_slot.pc + 16'd1 + i_slot.dec.imm;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

    // meaningful only for alu writers, loads get theirs from memory
    assign o_nzp = nzp_of(o_result);

endmodule

/* verilog/lc4ss_regfile.sv */
`timescale 1ns/1ps
`include "lc4ss_macros.svh"

module lc4ss_regfile import lc4ss_pkg::*; (
    input  logic                   gwe,
    input  logic                   i_rst,
    input  logic [`LC4_RSEL_W-1:0] i_rs_a,
    input  logic [`LC4_RSEL_W-1:0] i_rt_a,
    input  logic [`LC4_RSEL_W-1:0] i_rs_b,
    input  logic [`LC4_RSEL_W-1:0] i_rt_b,
    output logic [`LC4_W-1:0]      o_rs_a,
    output logic [`LC4_W-1:0]      o_rt_a,
    output logic [`LC4_W-1:0]      o_rs_b,
    output logic [`LC4_W-1:0]      o_rt_b,
    input  slot_t                  i_wr_a,
    input  slot_t                  i_wr_b
);

    logic [`LC4_W-1:0] regs [`LC4_NREG];
    logic              we_a;
    logic              we_b;

    assign we_a = i_wr_a.valid && i_wr_a.dec.reg_we;
    assign we_b = i_wr_b.valid && i_wr_b.dec.reg_we;

    // lane b is written last so it wins on the same register
    always_ff @(posedge gwe) begin
        if (i_rst) begin
            for (int i = 0; i < `LC4_NREG; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we_a) begin
                regs[i_wr_a.dec.rd] <= i_wr_a.result;
            end
            if (we_b) begin
                regs[i_wr_b.dec.rd] <= i_wr_b.result;
            end
        end
    end

    // write-through so decode sees this cycle's writeback
    function automatic logic [`LC4_W-1:0] rd_port(
        input logic [`LC4_RSEL_W-1:0] sel,
        input logic [`LC4_W-1:0]      stored
    );
        logic [`LC4_W-1:0] value;
        value = stored;
        if (we_a && i_wr_a.dec.rd == sel) begin
            value = i_wr_a.result;
        end
        if (we_b && i_wr_b.dec.rd == sel) begin
            value = i_wr_b.result;
        end
        return value;
    endfunction

    always_comb begin
        o_rs_a = rd_port(i_rs_a, regs[i_rs_a]);
        o_rt_a = rd_port(i_rt_a, regs[i_rt_a]);
        o_rs_b = rd_port(i_rs_b, regs[i_rs_b]);
        o_rt_b = rd_port(i_rt_b, regs[i_rt_b]);
    end

endmodule

/* verilog/lc4ss_decoder.sv */
`timescale 1ns/1ps
`include "lc4ss_macros.svh"

module lc4ss_decoder import lc4ss_pkg::*; (
    input  logic [`LC4_W-1:0] i_insn,
    output decoded_t          o_dec
);

    always_comb begin
        o_dec        = '0;
        o_dec.rs     = i_insn[8:6];
        o_dec.rt     = i_insn[2:0];
        o_dec.rd     = i_insn[11:9];
        o_dec.opcode = OP_NOP;
        case (i_insn[15:12])
            4'b0000: begin
                // br with nzp clear stays a nop
                if (i_insn[11:9] != 3'b000) begin
                    o_dec.opcode  = OP_BR;
                    o_dec.br_cond = i_insn[11:9];
                    o_dec.imm     = {{7{i_insn[8]}}, i_insn[8:0]};
                end
            end
            4'b0001: begin
                if (i_insn[5]) begin
                    o_dec.opcode = OP_ADDI;
                    o_dec.imm    = {{11{i_insn[4]}}, i_insn[4:0]};
                end else if (i_insn[5:3] == 3'b000) begin
                    o_dec.opcode = OP_ADD;
                end
            end
            4'b0101: begin
                if (i_insn[5:3] == 3'b000) begin
                    o_dec.opcode = OP_AND;
                end
            end
            4'b0110: begin
                o_dec.opcode = OP_LDR;
                o_dec.imm    = {{10{i_insn[5]}}, i_insn[5:0]};
            end
            4'b0111: begin
                // store data sits in the rd field, base in rs
                o_dec.opcode = OP_STR;
                o_dec.rt     = i_insn[11:9];
                o_dec.imm    = {{10{i_insn[5]}}, i_insn[5:0]};
            end
            4'b1001: begin
                o_dec.opcode = OP_CONST;
                o_dec.imm    = {{7{i_insn[8]}}, i_insn[8:0]};
            end
            default: begin
                o_dec.opcode = OP_NOP;
            end
        endcase
        // every register writer also sets nzp
        o_dec.reg_we    = o_dec.opcode inside {OP_ADD, OP_ADDI, OP_AND, OP_CONST, OP_LDR};
        o_dec.nzp_we    = o_dec.reg_we;
        o_dec.rs_re     = o_dec.opcode inside {OP_ADD, OP_ADDI, OP_AND, OP_LDR, OP_STR};
        o_dec.rt_re     = o_dec.opcode inside {OP_ADD, OP_AND, OP_STR};
        o_dec.is_load   = (o_dec.opcode == OP_LDR);
        o_dec.is_store  = (o_dec.opcode == OP_STR);
        o_dec.is_branch = (o_dec.opcode == OP_BR);
    end

endmodule

/* verilog/lc4ss_pkg.sv */
`include "lc4ss_macros.svh"

package lc4ss_pkg;

    // operation classes of the reduced lc4 set
    // anything not listed decodes to OP_NOP
    typedef enum logic [2:0] {
        OP_NOP,
        OP_BR,
        OP_ADD,
        OP_ADDI,
        OP_AND,
        OP_CONST,
        OP_LDR,
        OP_STR
    } opcode_e;

    // what happens to the decode pair this cycle
    typedef enum logic [1:0] {
        ISSUE_PAIR,
        ISSUE_SWITCH,
        ISSUE_STALL,
        ISSUE_FLUSH
    } issue_e;

    typedef struct packed {
        opcode_e                opcode;
        logic [`LC4_RSEL_W-1:0] rs;
        logic [`LC4_RSEL_W-1:0] rt;
        logic [`LC4_RSEL_W-1:0] rd;
        logic                   rs_re;
        logic                   rt_re;
        logic                   reg_we;
        logic                   nzp_we;
        logic                   is_load;
        logic                   is_store;
        logic                   is_branch;
        logic [`LC4_NZP_W-1:0]  br_cond;
        // already sign extended
        logic [`LC4_W-1:0]      imm;
    } decoded_t;

    // one lane entry as it moves d -> x -> m -> w
    typedef struct packed {
        logic              valid;
        logic [`LC4_W-1:0] pc;
        logic [`LC4_W-1:0] insn;
        decoded_t          dec;
        logic [`LC4_W-1:0] rs_val;
        logic [`LC4_W-1:0] rt_val;
        // alu value, memory address, branch target or load data in w
        logic [`LC4_W-1:0] result;
    } slot_t;

    // condition code of a value read as signed
    function automatic logic [`LC4_NZP_W-1:0] nzp_of(input logic [`LC4_W-1:0] value);
        logic [`LC4_NZP_W-1:0] bits;
        if (value[`LC4_W-1]) begin
            bits = 3'b100;
        end else if (value == '0) begin
            bits = 3'b010;
        end else begin
            bits = 3'b001;
        end
        return bits;
    endfunction

endpackage

/* include/lc4ss_macros.svh */
`ifndef LC4SS_MACROS_SVH
`define LC4SS_MACROS_SVH

// data and address width
`define LC4_W 16

// architectural registers r0..r7
`define LC4_NREG 8
`define LC4_RSEL_W 3

// first fetch address out of reset
`define LC4_RESET_PC 16'h8200

// n, z, p condition bits
`define LC4_NZP_W 3

`endif
